// ==== Bender.yml ====
package:
  name: axi_mem

export_include_dirs:
  - common

sources:
  - common/axi_mem_pkg.sv
  - axi_mem/axi_mem_storage.sv
  - axi_mem/axi_mem_write_path.sv
  - axi_mem/axi_mem_read_path.sv
  - hdl/axi_mem_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/axi_mem_checker.sv
      - tests/axi_mem_tb.sv

// ==== axi_mem/axi_mem_read_path.sv ====
/*
 * AXI4-Lite read side of the slave memory.
 * One cycle from AR transfer to rvalid; R is held under back-pressure
 * and a new AR may transfer on the same edge as R.
 */

`include "axi_mem_settings.svh"

module axi_mem_read_path (
    input  logic                         clk,
    input  logic                         rst_n,
    // Read address channel
    input  logic [`AXI_MEM_ADDR_W-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    // Read data channel
    output logic [`AXI_MEM_DATA_W-1:0]   rdata,
    output axi_mem_pkg::axi_resp_e       rresp,
    output logic                         rvalid,
    input  logic                         rready,
    // Store read port
    output logic                         mem_re,
    output axi_mem_pkg::word_idx_t       mem_raddr,
    input  logic [`AXI_MEM_DATA_W-1:0]   mem_rdata
);
    import axi_mem_pkg::*;

    logic rvalid_q;
    logic err_q;
    logic ar_fire;
    logic ar_in_window;

    // ==================================================
    // Address acceptance
    // ==================================================
    // Slot is free when empty or being drained this cycle
    assign arready      = !rvalid_q || rready;
    assign ar_fire      = arvalid && arready;
    assign ar_in_window = in_window(araddr);

    // Store is only touched for addresses it owns
    assign mem_re    = ar_fire && ar_in_window;
    assign mem_raddr = word_index(araddr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            if (ar_fire) begin
                rvalid_q <= 1'b1;
                err_q    <= !ar_in_window;
            end else if (rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // ==================================================
    // Read data channel
    // ==================================================
    assign rvalid = rvalid_q;

    // Store read register holds while mem_re is low, so data stays put
    always_comb begin
        if (err_q) begin
            rdata = `AXI_MEM_ERR_WORD;
            rresp = resp_slverr;
        end else begin
            rdata = mem_rdata;
            rresp = resp_okay;
        end
    end

endmodule

// ==== axi_mem/axi_mem_storage.sv ====
/*
 * Dual-port word store organised as byte lanes.
 * Write port with per-lane enables, registered read port that loads on re.
 * A same-word read and write on one edge returns the old word.
 */

module axi_mem_storage (
    input  logic                              clk,
    // Write port
    input  logic                              we,
    input  axi_mem_pkg::word_idx_t            waddr,
    input  logic [axi_mem_pkg::strb_w*8-1:0]  wdata,
    input  logic [axi_mem_pkg::strb_w-1:0]    wstrb,
    // Read port
    input  logic                              re,
    input  axi_mem_pkg::word_idx_t            raddr,
    output logic [axi_mem_pkg::strb_w*8-1:0]  rdata
);
    import axi_mem_pkg::*;

    // ==================================================
    // One byte-wide array per lane
    // ==================================================
    for (genvar lane = 0; lane < strb_w; lane++) begin : g_lane
        logic [7:0] lane_mem [word_cnt];
        logic [7:0] rd_q;

        // Only enabled lanes of the addressed word change
        always_ff @(posedge clk) begin
            if (we && wstrb[lane]) begin
                lane_mem[waddr] <= wdata[8*lane +: 8];
            end
        end

        // Sampled before the write lands, so a collision reads old data
        always_ff @(posedge clk) begin
            if (re) begin
                rd_q <= lane_mem[raddr];
            end
        end

        assign rdata[8*lane +: 8] = rd_q;
    end

endmodule

// ==== axi_mem/axi_mem_write_path.sv ====
/*
 * AXI4-Lite write side of the slave memory.
 * Takes AW then W, checks the window once, drives the store write port
 * and returns the B response. One write in flight at most.
 */

`include "axi_mem_settings.svh"

module axi_mem_write_path (
    input  logic                            clk,
    input  logic                            rst_n,
    // Write address channel
    input  logic [`AXI_MEM_ADDR_W-1:0]      awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    // Write data channel
    input  logic [`AXI_MEM_DATA_W-1:0]      wdata,
    input  logic [axi_mem_pkg::strb_w-1:0]  wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    // Write response channel
    output axi_mem_pkg::axi_resp_e          bresp,
    output logic                            bvalid,
    input  logic                            bready,
    // Store write port
    output logic                            mem_we,
    output axi_mem_pkg::word_idx_t          mem_waddr,
    output logic [`AXI_MEM_DATA_W-1:0]      mem_wdata,
    output logic [axi_mem_pkg::strb_w-1:0]  mem_wstrb
);
    import axi_mem_pkg::*;

    wr_state_e state_q;
    wr_state_e state_d;
    word_idx_t widx_q;
    axi_resp_e resp_q;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;

    // ==================================================
    // Channel handshakes
    // ==================================================
    assign awready = (state_q == wr_addr);
    assign wready  = (state_q == wr_data);
    assign bvalid  = (state_q == wr_resp);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            wr_addr: begin
                if (aw_fire) begin
                    state_d = wr_data;
                end
            end
            wr_data: begin
                if (w_fire) begin
                    state_d = wr_resp;
                end
            end
            wr_resp: begin
                // Hold the response until the master takes it
                if (b_fire) begin
                    state_d = wr_addr;
                end
            end
            default: state_d = wr_addr;
        endcase
    end

    // Response code is decided at address time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= wr_addr;
            resp_q  <= resp_okay;
        end else begin
            state_q <= state_d;
            if (aw_fire) begin
                if (in_window(awaddr)) begin
                    resp_q <= resp_okay;
                end else begin
                    resp_q <= resp_slverr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            widx_q <= word_index(awaddr);
        end
    end

    // ==================================================
    // Store write port and B channel
    // ==================================================
    // Out-of-window writes never reach the store
    assign mem_we    = w_fire && (resp_q == resp_okay);
    assign mem_waddr = widx_q;
    assign mem_wdata = wdata;
    assign mem_wstrb = wstrb;

    assign bresp = resp_q;

endmodule

// ==== common/axi_mem_pkg.sv ====
/*
 * Types and helpers shared by the AXI4-Lite memory blocks.
 * Derived store widths, response and write FSM enums, address window math.
 */

`include "axi_mem_settings.svh"

package axi_mem_pkg;

    // Store geometry
    localparam int strb_w     = `AXI_MEM_DATA_W / 8;
    localparam int word_cnt   = `AXI_MEM_SIZE_BYTES / strb_w;
    localparam int word_idx_w = $clog2(word_cnt);

    typedef logic [word_idx_w-1:0] word_idx_t;

    // AXI response codes, only okay and slverr are produced
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    // Write channel ordering, address first then data then response
    typedef enum logic [1:0] {wr_addr, wr_data, wr_resp} wr_state_e;

    function automatic word_idx_t word_index(input logic [`AXI_MEM_ADDR_W-1:0] addr);
        logic [`AXI_MEM_ADDR_W-1:0] offset;
        offset = (addr - `AXI_MEM_BASE) >> 2;
        return offset[word_idx_w-1:0];
    endfunction

    function automatic logic in_window(input logic [`AXI_MEM_ADDR_W-1:0] addr);
        logic [`AXI_MEM_ADDR_W-1:0] offset;
        offset = addr - `AXI_MEM_BASE;
        return (addr >= `AXI_MEM_BASE) && (offset < `AXI_MEM_SIZE_BYTES);
    endfunction

endpackage

// ==== common/axi_mem_settings.svh ====
/*
 * Build-time sizes for the AXI4-Lite slave memory.
 * Included by the package and by every module that needs an address width.
 */

`ifndef AXI_MEM_SETTINGS_SVH
`define AXI_MEM_SETTINGS_SVH

// AXI address width in bits
`define AXI_MEM_ADDR_W 32

// AXI data width in bits, one word of the store
`define AXI_MEM_DATA_W 32

// Store size in bytes
`define AXI_MEM_SIZE_BYTES 4096

// First byte address answered by the memory
`define AXI_MEM_BASE 32'h8000_0000

// Data returned on an out-of-window read
`define AXI_MEM_ERR_WORD 32'hDEAD_BEEF

`endif

// ==== hdl/axi_mem_top.sv ====
/*
 * AXI4-Lite slave memory top level.
 * Joins the write path, the read path and the dual-port store to the bus pins.
 */

`include "axi_mem_settings.svh"

module axi_mem_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // Write address channel
    input  logic [`AXI_MEM_ADDR_W-1:0]      awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    // Write data channel
    input  logic [`AXI_MEM_DATA_W-1:0]      wdata,
    input  logic [axi_mem_pkg::strb_w-1:0]  wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    // Write response channel
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    // Read address channel
    input  logic [`AXI_MEM_ADDR_W-1:0]      araddr,
    input  logic                            arvalid,
    output logic                            arready,
    // Read data channel
    output logic [`AXI_MEM_DATA_W-1:0]      rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready
);
    import axi_mem_pkg::*;

    // Store ports
    logic                       mem_we;
    word_idx_t                  mem_waddr;
    logic [`AXI_MEM_DATA_W-1:0] mem_wdata;
    logic [strb_w-1:0]          mem_wstrb;
    logic                       mem_re;
    word_idx_t                  mem_raddr;
    logic [`AXI_MEM_DATA_W-1:0] mem_rdata;

    // Enum responses leave the top as plain 2-bit codes
    axi_resp_e                  bresp_e;
    axi_resp_e                  rresp_e;

    assign bresp = bresp_e;
    assign rresp = rresp_e;

    axi_mem_write_path u_write_path (
        .clk       (clk),       .rst_n     (rst_n),
        .awaddr    (awaddr),    .awvalid   (awvalid),   .awready (awready),
        .wdata     (wdata),     .wstrb     (wstrb),
        .wvalid    (wvalid),    .wready    (wready),
        .bresp     (bresp_e),   .bvalid    (bvalid),    .bready  (bready),
        .mem_we    (mem_we),    .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata), .mem_wstrb (mem_wstrb)
    );

    axi_mem_read_path u_read_path (
        .clk       (clk),       .rst_n     (rst_n),
        .araddr    (araddr),    .arvalid   (arvalid),   .arready (arready),
        .rdata     (rdata),     .rresp     (rresp_e),
        .rvalid    (rvalid),    .rready    (rready),
        .mem_re    (mem_re),    .mem_raddr (mem_raddr), .mem_rdata (mem_rdata)
    );

    axi_mem_storage u_storage (
        .clk   (clk),
        .we    (mem_we),    .waddr (mem_waddr),
        .wdata (mem_wdata), .wstrb (mem_wstrb),
        .re    (mem_re),    .raddr (mem_raddr), .rdata (mem_rdata)
    );

endmodule

// ==== tests/axi_mem_checker.sv ====
/*
 * Concurrent AXI4-Lite protocol and timing assertions for the slave memory.
 * Attached to every axi_mem_top by the bind statement at the end of this file.
 */

`include "axi_mem_settings.svh"

module axi_mem_checker (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       awready,
    input logic                       wready,
    input logic [1:0]                 bresp,
    input logic                       bvalid,
    input logic                       bready,
    input logic                       arvalid,
    input logic                       arready,
    input logic [`AXI_MEM_DATA_W-1:0] rdata,
    input logic [1:0]                 rresp,
    input logic                       rvalid,
    input logic                       rready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions so far
    int err_cnt = 0;

    function automatic void count_failure(input string what);
        $error("%s", what);
        err_cnt++;
    endfunction

    // ==================================================
    // Channel rules
    // ==================================================
    // Address phase and data phase never overlap
    a_aw_w_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(awready && wready))
        else count_failure("awready and wready high in the same cycle");

    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else count_failure("B response changed or dropped while stalled");

    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else count_failure("R response changed or dropped while stalled");

    // Fixed one-cycle read latency
    a_r_latency: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready |=> rvalid)
        else count_failure("rvalid not high one cycle after an AR transfer");

    // ==================================================
    // Reset behaviour
    // ==================================================
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !bvalid && !rvalid && !wready)
        else count_failure("bvalid, rvalid or wready high during reset");

endmodule

bind axi_mem_top axi_mem_checker u_checker (
    .clk     (clk),     .rst_n   (rst_n),
    .awready (awready), .wready  (wready),
    .bresp   (bresp),   .bvalid  (bvalid),  .bready (bready),
    .arvalid (arvalid), .arready (arready),
    .rdata   (rdata),   .rresp   (rresp),
    .rvalid  (rvalid),  .rready  (rready)
);

// ==== tests/axi_mem_tb.sv ====
/*
 * Testbench for the AXI4-Lite slave memory.
 * Runs write and read transactions against a byte model of the store and
 * compares every read response, with random stalls on bready and rready.
 */

`include "axi_mem_settings.svh"

module axi_mem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          clk_period  = 40;
    // Transactions in the sequence below rounded up
    localparam int          num_txn     = 64;
    localparam logic [1:0]  okay_code   = 2'b00;
    localparam logic [1:0]  slverr_code = 2'b10;
    // Last byte address that the memory answers
    localparam logic [31:0] last_addr   = `AXI_MEM_BASE + `AXI_MEM_SIZE_BYTES - 1;

    logic        clk;
    logic        rst_n;
    logic [31:0] awaddr;
    logic        awvalid, awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid, wready;
    logic [1:0]  bresp;
    logic        bvalid, bready;
    logic [31:0] araddr;
    logic        arvalid, arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid, rready;

    int          seed = 32'h695e;
    logic [7:0]  model [logic [31:0]];
    logic [31:0] rd_list[$];
    logic [31:0] exp_data[$];
    logic [31:0] exp_mask[$];
    logic [1:0]  exp_resp[$];
    time         w_fire_t;
    time         ar_fire_t;
    time         b1_t;
    time         aw2_t;

    axi_mem_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic expect_true(input logic ok, input string what);
        assert (ok === 1'b1)
            else abort_run($sformatf("[FAIL] %0t: %s", $time, what));
    endtask

    function automatic logic addr_hits_window(input logic [31:0] addr);
        return (addr >= `AXI_MEM_BASE) && (addr <= last_addr);
    endfunction

    // Idle cycles on a ready line between 0 and 3
    function automatic int pick_stall();
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic model_store(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        if (addr_hits_window(addr)) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (strb[lane]) begin
                    model[{addr[31:2], 2'b00} + 32'(lane)] = data[8*lane +: 8];
                end
            end
        end
    endtask

    // Bytes never written stay out of the mask
    task automatic push_expected(input logic [31:0] addr);
        logic [31:0] d;
        logic [31:0] m;
        d = '0;
        m = '0;
        if (!addr_hits_window(addr)) begin
            d = `AXI_MEM_ERR_WORD;
            m = '1;
        end else begin
            for (int lane = 0; lane < 4; lane++) begin
                if (model.exists({addr[31:2], 2'b00} + 32'(lane))) begin
                    d[8*lane +: 8] = model[{addr[31:2], 2'b00} + 32'(lane)];
                    m[8*lane +: 8] = 8'hFF;
                end
            end
        end
        exp_data.push_back(d);
        exp_mask.push_back(m);
        exp_resp.push_back(addr_hits_window(addr) ? okay_code : slverr_code);
    endtask

    // ==================================================
    // Channel tasks entered 2 ns after a rising edge
    // ==================================================
    task automatic aw_send(input logic [31:0] addr);
        awaddr  = addr;
        awvalid = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
    endtask

    task automatic w_send(input logic [31:0] data, input logic [3:0] strb);
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        @(negedge clk);
        while (!wready) @(negedge clk);
        @(posedge clk);
        #2;
        w_fire_t = $time;
        wvalid   = 1'b0;
    endtask

    task automatic b_take(input logic [1:0] want, input int stall);
        repeat (stall) begin
            @(posedge clk);
            #2;
        end
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        expect_true(bresp === want, $sformatf("bresp %0d, expected %0d", bresp, want));
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        aw_send(addr);
        w_send(data, strb);
        b_take(addr_hits_window(addr) ? okay_code : slverr_code, pick_stall());
        model_store(addr, data, strb);
    endtask

    // AR stays valid across the list, so reads go back to back
    task automatic issue_reads();
        foreach (rd_list[i]) begin
            araddr  = rd_list[i];
            arvalid = 1'b1;
            @(negedge clk);
            while (!arready) @(negedge clk);
            @(posedge clk);
            #2;
            ar_fire_t = $time;
            push_expected(rd_list[i]);
        end
        arvalid = 1'b0;
    endtask

    task automatic collect_reads(input int n);
        int stall;
        repeat (n) begin
            stall = pick_stall();
            if (stall > 0) begin
                rready = 1'b0;
                repeat (stall) begin
                    @(posedge clk);
                    #2;
                end
            end
            rready = 1'b1;
            @(negedge clk);
            while (!rvalid) @(negedge clk);
            expect_true(exp_data.size() != 0, "R transfer with no read outstanding");
            expect_true(((rdata ^ exp_data[0]) & exp_mask[0]) === 32'h0,
                $sformatf("rdata %h, expected %h under mask %h", rdata, exp_data[0],
                          exp_mask[0]));
            expect_true(rresp === exp_resp[0],
                $sformatf("rresp %0d, expected %0d", rresp, exp_resp[0]));
            void'(exp_data.pop_front());
            void'(exp_mask.pop_front());
            void'(exp_resp.pop_front());
            @(posedge clk);
            #2;
        end
        rready = 1'b0;
    endtask

    task automatic run_reads();
        fork
            issue_reads();
            collect_reads(rd_list.size());
        join
        rd_list.delete();
    endtask

    // ==================================================
    // Watchdogs
    // ==================================================
    initial begin
        #((num_txn * 40 + 10) * clk_period);
        abort_run("The run timed out before all transactions finished");
    end

    initial begin
        wait (u_dut.u_checker.err_cnt != 0);
        abort_run("The protocol checker reported an assertion failure");
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        rst_n   = 1'b1;
        #1;
        rst_n   = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n   = 1'b1;

        // Full words
        write_word(`AXI_MEM_BASE + 32'h000, 32'h0123_4567, 4'hF);
        write_word(`AXI_MEM_BASE + 32'h004, 32'h89AB_CDEF, 4'hF);
        write_word(`AXI_MEM_BASE + 32'h100, 32'hCAFE_F00D, 4'hF);
        write_word(`AXI_MEM_BASE + 32'hFFC, 32'h5A5A_A5A5, 4'hF);
        rd_list = {`AXI_MEM_BASE, `AXI_MEM_BASE + 32'h4, `AXI_MEM_BASE + 32'h100};
        rd_list.push_back(`AXI_MEM_BASE + 32'hFFC);
        run_reads();

        // Byte lanes merge into the word
        write_word(`AXI_MEM_BASE + 32'h020, 32'h1122_3344, 4'hF);
        write_word(`AXI_MEM_BASE + 32'h020, 32'hAABB_CCDD, 4'b0101);
        write_word(`AXI_MEM_BASE + 32'h020, 32'h99EE_EEEE, 4'b1000);
        write_word(`AXI_MEM_BASE + 32'h040, 32'h0000_7700, 4'b0010);
        rd_list = {`AXI_MEM_BASE + 32'h020, `AXI_MEM_BASE + 32'h040};
        run_reads();

        // Outside the window where the first two alias the first and last words
        write_word(32'h8000_1000, 32'hFFFF_FFFF, 4'hF);
        write_word(32'h7FFF_FFFC, 32'hFFFF_FFFF, 4'hF);
        write_word(32'h0000_0010, 32'hFFFF_FFFF, 4'hF);
        rd_list = {`AXI_MEM_BASE, `AXI_MEM_BASE + 32'hFFC, 32'h8000_1000, 32'h7FFF_FFFC};
        run_reads();

        // Back-to-back reads under random rready stalls
        for (int i = 0; i < 16; i++) begin
            write_word(`AXI_MEM_BASE + 32'(i * 4), $random(seed), 4'hF);
        end
        for (int i = 0; i < 16; i++) begin
            rd_list.push_back(`AXI_MEM_BASE + 32'(($unsigned($random(seed)) % 24) * 4));
        end
        rd_list.push_back(32'h0000_0000);
        run_reads();

        // Read and write of one word on the same edge
        write_word(`AXI_MEM_BASE + 32'h080, 32'h1111_1111, 4'hF);
        aw_send(`AXI_MEM_BASE + 32'h080);
        rd_list.push_back(`AXI_MEM_BASE + 32'h080);
        fork
            w_send(32'h2222_2222, 4'hF);
            run_reads();
        join
        expect_true(w_fire_t == ar_fire_t, "colliding read and write took different edges");
        b_take(okay_code, 0);
        model_store(`AXI_MEM_BASE + 32'h080, 32'h2222_2222, 4'hF);
        rd_list.push_back(`AXI_MEM_BASE + 32'h080);
        run_reads();

        // Held bready blocks the next AW
        aw_send(`AXI_MEM_BASE + 32'h200);
        w_send(32'h3333_3333, 4'hF);
        fork
            begin
                aw_send(`AXI_MEM_BASE + 32'h204);
                aw2_t = $time;
            end
            begin
                b_take(okay_code, 6);
                b1_t = $time;
            end
        join
        model_store(`AXI_MEM_BASE + 32'h200, 32'h3333_3333, 4'hF);
        expect_true(aw2_t > b1_t, "second AW accepted while the first B was pending");
        w_send(32'h4444_4444, 4'hF);
        b_take(okay_code, pick_stall());
        model_store(`AXI_MEM_BASE + 32'h204, 32'h4444_4444, 4'hF);
        rd_list = {`AXI_MEM_BASE + 32'h200, `AXI_MEM_BASE + 32'h204};
        run_reads();

        repeat (4) @(posedge clk);
        if (u_dut.u_checker.err_cnt != 0) begin
            abort_run("The protocol checker reported an assertion failure");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/axi_mem_pkg.sv
axi_mem/axi_mem_storage.sv
axi_mem/axi_mem_write_path.sv
axi_mem/axi_mem_read_path.sv
hdl/axi_mem_top.sv
tests/axi_mem_checker.sv
tests/axi_mem_tb.sv
